// File: verilog/ahb_pkg.sv
package ahb_pkg;

    // bus widths
    localparam int ADDR_W    = 16;
    localparam int DATA_W    = 32;
    // upper address bits that pick a bank
    localparam int BANK_BITS = 2;

    // htrans codes, only idle and nonseq are issued
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

    localparam logic [2:0] HBURST_SINGLE = 3'b000;
    localparam logic [2:0] HSIZE_WORD    = 3'b010;

    localparam logic       HRESP_OKAY    = 1'b0;
    localparam logic       HRESP_ERROR   = 1'b1;

    // bit0 set marks a data access
    localparam logic [3:0] HPROT_DATA    = 4'b0001;

    typedef struct packed {
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
        logic              we;
        logic              cyc;
        logic              stb;
    } wb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] dat;
        logic              ack;
        logic              err;
    } wb_rsp_t;

    typedef struct packed {
        logic              hsel;
        logic [1:0]        htrans;
        logic [ADDR_W-1:0] haddr;
        logic              hwrite;
        logic [2:0]        hsize;
        logic [2:0]        hburst;
        logic [3:0]        hprot;
        logic [DATA_W-1:0] hwdata;
    } ahb_req_t;

    typedef struct packed {
        logic              hready;
        logic              hresp;
        logic [DATA_W-1:0] hrdata;
    } ahb_rsp_t;

endpackage

// File: verilog/wb_bank_dispatch.sv
module wb_bank_dispatch #(
    parameter int NUM_BANKS = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  ahb_pkg::wb_req_t               wb_i,
    input  logic                           done_i,
    output ahb_pkg::wb_req_t               bank_req_o [NUM_BANKS],
    output logic [ahb_pkg::BANK_BITS-1:0]  bank_sel_o
);

    // offset bits left once the bank field is stripped
    localparam int OFF_W = ahb_pkg::ADDR_W - ahb_pkg::BANK_BITS;

    logic                          busy_q;
    logic [ahb_pkg::BANK_BITS-1:0] bank_q;
    logic [ahb_pkg::BANK_BITS-1:0] adr_bank;
    logic                          start;

    assign adr_bank = wb_i.adr[ahb_pkg::ADDR_W-1 -: ahb_pkg::BANK_BITS];

    // first stb cycle of a new wishbone cycle
    assign start = wb_i.cyc & wb_i.stb & ~busy_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            bank_q <= '0;
        end else if (done_i) begin
            busy_q <= 1'b0;
        end else if (start) begin
            busy_q <= 1'b1;
            bank_q <= adr_bank;
        end
    end

    // decode straight from adr on the first cycle so no cycle is added
    assign bank_sel_o = busy_q ? bank_q : adr_bank;

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_req_o[b]     = wb_i;
            bank_req_o[b].adr = {{ahb_pkg::BANK_BITS{1'b0}}, wb_i.adr[OFF_W-1:0]};
            // strobe reaches the addressed bank only
            if (bank_sel_o != ahb_pkg::BANK_BITS'(b)) begin
                bank_req_o[b].cyc = 1'b0;
                bank_req_o[b].stb = 1'b0;
            end
        end
    end

endmodule

// File: verilog/ahb_bank_bridge.sv
module ahb_bank_bridge (
    input  logic              clk,
    input  logic              rst_n,
    input  ahb_pkg::wb_req_t  wb_i,
    output ahb_pkg::wb_rsp_t  wb_o,
    output ahb_pkg::ahb_req_t ahb_o,
    input  ahb_pkg::ahb_rsp_t ahb_i
);

    // one single transfer per wishbone cycle
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_RESP
    } state_e;

    state_e                      state_q;
    state_e                      state_d;

    logic                        hsel_q;
    logic [1:0]                  htrans_q;
    logic [ahb_pkg::ADDR_W-1:0]  haddr_q;
    logic                        hwrite_q;
    logic [ahb_pkg::DATA_W-1:0]  hwdata_q;
    logic [ahb_pkg::DATA_W-1:0]  rdata_q;
    logic                        err_q;
    logic                        req_start;
    logic                        data_done;

    assign req_start = wb_i.cyc & wb_i.stb;
    assign data_done = (state_q == ST_DATA) & ahb_i.hready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_start) begin
                    state_d = ST_ADDR;
                end
            end
            ST_ADDR: begin
                state_d = ST_DATA;
            end
            ST_DATA: begin
                // slave stretches the data phase with hready low
                if (ahb_i.hready) begin
                    state_d = ST_RESP;
                end
            end
            ST_RESP: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // address phase control and write data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hsel_q   <= 1'b0;
            htrans_q <= ahb_pkg::HTRANS_IDLE;
            haddr_q  <= '0;
            hwrite_q <= 1'b0;
            hwdata_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_start) begin
                        hsel_q   <= 1'b1;
                        htrans_q <= ahb_pkg::HTRANS_NONSEQ;
                        haddr_q  <= wb_i.adr;
                        hwrite_q <= wb_i.we;
                    end
                end
                ST_ADDR: begin
                    hsel_q   <= 1'b0;
                    htrans_q <= ahb_pkg::HTRANS_IDLE;
                    hwdata_q <= hwrite_q ? wb_i.dat : '0;
                end
                ST_DATA: begin
                    if (ahb_i.hready) begin
                        hwdata_q <= '0;
                    end
                end
                ST_RESP: begin
                    hwrite_q <= 1'b0;
                end
                default: begin
                    hsel_q <= 1'b0;
                end
            endcase
        end
    end

    // response status from the last data cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_q <= 1'b0;
        end else if (data_done) begin
            err_q <= (ahb_i.hresp == ahb_pkg::HRESP_ERROR);
        end
    end

    always_ff @(posedge clk) begin
        if (data_done) begin
            rdata_q <= ahb_i.hrdata;
        end
    end

    always_comb begin
        ahb_o.hsel   = hsel_q;
        ahb_o.htrans = htrans_q;
        ahb_o.haddr  = haddr_q;
        ahb_o.hwrite = hwrite_q;
        ahb_o.hsize  = ahb_pkg::HSIZE_WORD;
        ahb_o.hburst = ahb_pkg::HBURST_SINGLE;
        ahb_o.hprot  = ahb_pkg::HPROT_DATA;
        ahb_o.hwdata = hwdata_q;

        wb_o.dat = rdata_q;
        wb_o.ack = (state_q == ST_RESP) & ~err_q;
        wb_o.err = (state_q == ST_RESP) & err_q;
    end

endmodule

// File: verilog/ahb_sram_bank.sv
module ahb_sram_bank #(
    parameter int BANK_WORDS  = 256,
    parameter int WAIT_STATES = 1
) (
    input  logic              clk,
    input  logic              rst_n,
    input  ahb_pkg::ahb_req_t ahb_i,
    output ahb_pkg::ahb_rsp_t ahb_o
);

    localparam int IDX_W     = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;
    localparam int CNT_W     = (WAIT_STATES > 1) ? $clog2(WAIT_STATES) : 1;
    localparam int LAST_WAIT = (WAIT_STATES > 0) ? WAIT_STATES - 1 : 0;
    // word offset, the two byte bits are dropped
    localparam int OFF_W     = ahb_pkg::ADDR_W - 2;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT,
        ST_DONE,
        ST_ERR1,
        ST_ERR2
    } state_e;

    state_e                     state_q;
    state_e                     state_d;
    logic [CNT_W-1:0]           cnt_q;
    logic                       we_q;
    logic [IDX_W-1:0]           idx_q;
    logic [OFF_W-1:0]           word_off;
    logic                       out_of_range;
    logic                       addr_valid;
    logic                       hready;
    logic [ahb_pkg::DATA_W-1:0] mem_q [BANK_WORDS];

    assign hready       = (state_q != ST_WAIT) && (state_q != ST_ERR1);
    assign addr_valid   = ahb_i.hsel && (ahb_i.htrans == ahb_pkg::HTRANS_NONSEQ) && hready;
    assign word_off     = ahb_i.haddr[ahb_pkg::ADDR_W-1:2];
    assign out_of_range = 32'(word_off) >= BANK_WORDS;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_WAIT: begin
                if (cnt_q == CNT_W'(LAST_WAIT)) begin
                    state_d = ST_DONE;
                end
            end
            ST_ERR1: begin
                state_d = ST_ERR2;
            end
            default: begin
                // hready is high here, so a new address phase may start
                state_d = ST_IDLE;
                if (addr_valid) begin
                    if (out_of_range) begin
                        state_d = ST_ERR1;
                    end else if (WAIT_STATES == 0) begin
                        state_d = ST_DONE;
                    end else begin
                        state_d = ST_WAIT;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            we_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            cnt_q   <= (state_q == ST_WAIT) ? cnt_q + 1'b1 : '0;
            if (addr_valid) begin
                we_q <= ahb_i.hwrite;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (addr_valid) begin
            idx_q <= word_off[IDX_W-1:0];
        end
    end

    // hwdata is valid in the completing data cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < BANK_WORDS; w++) begin
                mem_q[w] <= '0;
            end
        end else if ((state_q == ST_DONE) && we_q) begin
            mem_q[idx_q] <= ahb_i.hwdata;
        end
    end

    always_comb begin
        ahb_o.hready = hready;
        ahb_o.hresp  = ((state_q == ST_ERR1) || (state_q == ST_ERR2)) ?
                       ahb_pkg::HRESP_ERROR : ahb_pkg::HRESP_OKAY;
        ahb_o.hrdata = ((state_q == ST_DONE) && !we_q) ? mem_q[idx_q] : '0;
    end

endmodule

// File: verilog/wb_resp_collect.sv
module wb_resp_collect #(
    parameter int NUM_BANKS = 4
) (
    input  ahb_pkg::wb_rsp_t              bank_rsp_i [NUM_BANKS],
    input  logic [ahb_pkg::BANK_BITS-1:0] bank_sel_i,
    output ahb_pkg::wb_rsp_t              wb_o
);

    ahb_pkg::wb_rsp_t sel_rsp;
    logic             stray;
    logic             resp_hit;

    always_comb begin
        sel_rsp = bank_rsp_i[bank_sel_i];
        stray   = 1'b0;
        // any response from a bank that is not selected
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (ahb_pkg::BANK_BITS'(b) != bank_sel_i) begin
                stray = stray | bank_rsp_i[b].ack | bank_rsp_i[b].err;
            end
        end
    end

    assign resp_hit = sel_rsp.ack | sel_rsp.err;

    always_comb begin
        // quiet port while the selected bridge is not responding
        wb_o.dat = resp_hit ? sel_rsp.dat : '0;
        // a stray response turns the active ack into err
        wb_o.ack = sel_rsp.ack & ~stray;
        wb_o.err = sel_rsp.err | (sel_rsp.ack & stray);
    end

endmodule

// File: verilog/ahb_mem_subsys.sv
module ahb_mem_subsys #(
    parameter int NUM_BANKS   = 4,
    parameter int BANK_WORDS  = 256,
    parameter int WAIT_STATES = 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  ahb_pkg::wb_req_t wb_i,
    output ahb_pkg::wb_rsp_t wb_o
);

    // one request and response pair per bank segment
    ahb_pkg::wb_req_t              bank_req [NUM_BANKS];
    ahb_pkg::wb_rsp_t              bank_rsp [NUM_BANKS];
    ahb_pkg::ahb_req_t             ahb_req  [NUM_BANKS];
    ahb_pkg::ahb_rsp_t             ahb_rsp  [NUM_BANKS];
    logic [ahb_pkg::BANK_BITS-1:0] bank_sel;
    logic                          port_done;

    // the port cycle ends on ack or err
    assign port_done = wb_o.ack | wb_o.err;

    // bank field must cover exactly the banks built
    if (NUM_BANKS != 2 ** ahb_pkg::BANK_BITS) begin : g_cfg_check
        $error("NUM_BANKS does not match the bank select width");
    end

    wb_bank_dispatch #(
        .NUM_BANKS (NUM_BANKS)
    ) dispatch_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_i       (wb_i),
        .done_i     (port_done),
        .bank_req_o (bank_req),
        .bank_sel_o (bank_sel)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        ahb_bank_bridge bridge_i (
            .clk   (clk),
            .rst_n (rst_n),
            .wb_i  (bank_req[b]),
            .wb_o  (bank_rsp[b]),
            .ahb_o (ahb_req[b]),
            .ahb_i (ahb_rsp[b])
        );

        ahb_sram_bank #(
            .BANK_WORDS  (BANK_WORDS),
            .WAIT_STATES (WAIT_STATES)
        ) bank_i (
            .clk   (clk),
            .rst_n (rst_n),
            .ahb_i (ahb_req[b]),
            .ahb_o (ahb_rsp[b])
        );
    end

    wb_resp_collect #(
        .NUM_BANKS (NUM_BANKS)
    ) collect_i (
        .bank_rsp_i (bank_rsp),
        .bank_sel_i (bank_sel),
        .wb_o       (wb_o)
    );

endmodule

// File: dv/ahb_mem_subsys_sva.sv
module ahb_mem_subsys_sva #(
    parameter int NUM_BANKS = 4
) (
    input logic                          clk,
    input logic                          rst_n,
    input ahb_pkg::wb_req_t              wb_req_i,
    input ahb_pkg::wb_rsp_t              wb_rsp_i,
    input ahb_pkg::ahb_req_t             ahb_req_i [NUM_BANKS],
    input ahb_pkg::ahb_rsp_t             ahb_rsp_i [NUM_BANKS],
    input logic [ahb_pkg::BANK_BITS-1:0] bank_sel_i
);
    timeunit 1ns;
    timeprecision 100ps;

    ack_err_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(wb_rsp_i.ack && wb_rsp_i.err))
        else $error("port ack and err high in the same cycle");

    // a response only answers a live strobe
    ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp_i.ack |-> (wb_req_i.cyc && wb_req_i.stb))
        else $error("port ack without cyc and stb");

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        idle_unless_sel: assert property (@(posedge clk) disable iff (!rst_n)
            (bank_sel_i != ahb_pkg::BANK_BITS'(b)) |->
            (ahb_req_i[b].htrans == ahb_pkg::HTRANS_IDLE))
            else $error("bank %0d issued a transfer while not selected", b);

        // stretched data phase keeps the transfer direction
        hwrite_stable: assert property (@(posedge clk) disable iff (!rst_n)
            !ahb_rsp_i[b].hready |=> $stable(ahb_req_i[b].hwrite))
            else $error("bank %0d hwrite changed during a wait state", b);
    end

endmodule

bind ahb_mem_subsys ahb_mem_subsys_sva #(
    .NUM_BANKS (NUM_BANKS)
) sva_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_req_i   (wb_i),
    .wb_rsp_i   (wb_o),
    .ahb_req_i  (ahb_req),
    .ahb_rsp_i  (ahb_rsp),
    .bank_sel_i (bank_sel)
);

// File: dv/tb_ahb_mem_subsys.sv
module tb_ahb_mem_subsys;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 4;
    localparam int RST_CYCLES  = 3;
    localparam int NUM_BANKS   = 4;
    localparam int BANK_WORDS  = 256;
    localparam int WAIT_STATES = 2;
    localparam int IDX_W       = $clog2(BANK_WORDS);
    localparam int OFF_W       = ahb_pkg::ADDR_W - ahb_pkg::BANK_BITS;
    // cycle bound for a single transfer
    localparam int XFER_CYCLES = 20;
    localparam int NUM_RANDOM  = 64;
    // 4 + 8 + 8 + 4 transfers in the directed tests, then the random ones
    localparam int NUM_XFERS   = 24 + NUM_RANDOM;
    localparam int WDOG_CYCLES = NUM_XFERS * XFER_CYCLES + RST_CYCLES + 16;

    logic                       clk;
    logic                       rst_n;
    ahb_pkg::wb_req_t           wb_req;
    ahb_pkg::wb_rsp_t           wb_rsp;
    logic [31:0]                lfsr_q = 32'd91224;
    logic [ahb_pkg::DATA_W-1:0] model [NUM_BANKS][BANK_WORDS];
    bit                         verdict_done;

    ahb_mem_subsys #(
        .NUM_BANKS   (NUM_BANKS),
        .BANK_WORDS  (BANK_WORDS),
        .WAIT_STATES (WAIT_STATES)
    ) ahb_mem_subsys_i (
        .clk   (clk),
        .rst_n (rst_n),
        .wb_i  (wb_req),
        .wb_o  (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_q[0]};
            if (lfsr_q[0]) begin
                lfsr_q = (lfsr_q >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_q = lfsr_q >> 1;
            end
        end
        return val;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        verdict_done = 1'b1;
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0d ns: %s got 0x%h expected 0x%h",
                                $time, name, got, exp));
        end
    endtask

    task automatic bus_release();
        @(posedge clk);
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        wb_req.we  <= 1'b0;
    endtask

    // one wishbone cycle, returns at the negedge that shows ack or err
    task automatic wb_xfer(input logic we, input logic [1:0] bank, input int word,
                           input logic [31:0] wdata, output ahb_pkg::wb_rsp_t rsp);
        int waited;
        @(posedge clk);
        wb_req.adr <= {bank, OFF_W'(word * 4)};
        wb_req.dat <= wdata;
        wb_req.we  <= we;
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!(wb_rsp.ack || wb_rsp.err) && waited < XFER_CYCLES);
        if (!(wb_rsp.ack || wb_rsp.err)) begin
            abort_run($sformatf("ERROR: bank %0d gave no ack or err within %0d cycles",
                                bank, XFER_CYCLES));
        end
        rsp = wb_rsp;
    endtask

    task automatic wb_write(input logic [1:0] bank, input int word,
                            input logic [31:0] data, input logic exp_err);
        ahb_pkg::wb_rsp_t rsp;
        wb_xfer(1'b1, bank, word, data, rsp);
        check_eq("wb_o.ack", 32'(rsp.ack), 32'(!exp_err));
        check_eq("wb_o.err", 32'(rsp.err), 32'(exp_err));
        if (!exp_err) begin
            model[bank][IDX_W'(word)] = data;
        end
    endtask

    task automatic wb_read(input logic [1:0] bank, input int word, input logic exp_err);
        ahb_pkg::wb_rsp_t rsp;
        wb_xfer(1'b0, bank, word, '0, rsp);
        check_eq("wb_o.ack", 32'(rsp.ack), 32'(!exp_err));
        check_eq("wb_o.err", 32'(rsp.err), 32'(exp_err));
        if (!exp_err) begin
            check_eq("wb_o.dat", rsp.dat, model[bank][IDX_W'(word)]);
        end
    endtask

    task automatic check_reset_values();
        @(negedge clk);
        check_eq("wb_o.ack", 32'(wb_rsp.ack), 32'd0);
        check_eq("wb_o.err", 32'(wb_rsp.err), 32'd0);
        // memory comes out of reset cleared
        for (int b = 0; b < NUM_BANKS; b++) begin
            wb_read(2'(b), int'(rand_bits(IDX_W)), 1'b0);
        end
        bus_release();
    endtask

    task automatic write_read_back();
        int word;
        for (int b = 0; b < NUM_BANKS; b++) begin
            word = int'(rand_bits(IDX_W));
            wb_write(2'(b), word, rand_bits(32), 1'b0);
            wb_read(2'(b), word, 1'b0);
        end
        bus_release();
    endtask

    task automatic bank_isolation();
        int word;
        word = int'(rand_bits(IDX_W));
        for (int b = 0; b < NUM_BANKS; b++) begin
            wb_write(2'(b), word, rand_bits(32), 1'b0);
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            wb_read(2'(b), word, 1'b0);
        end
        bus_release();
    endtask

    task automatic out_of_range_access();
        logic [1:0] bank;
        bank = 2'(rand_bits(2));
        wb_write(bank, 0, rand_bits(32), 1'b0);
        // offset BANK_WORDS shares its low index bits with word 0
        wb_write(bank, BANK_WORDS, rand_bits(32), 1'b1);
        wb_read(bank, BANK_WORDS + int'(rand_bits(IDX_W)), 1'b1);
        wb_read(bank, 0, 1'b0);
        bus_release();
    endtask

    task automatic random_traffic();
        logic       we;
        logic [1:0] bank;
        int         word;
        // each request follows the previous ack directly
        for (int i = 0; i < NUM_RANDOM; i++) begin
            we   = rand_bits(1) != 0;
            bank = 2'(rand_bits(2));
            word = int'(rand_bits(IDX_W));
            if (we) begin
                wb_write(bank, word, rand_bits(32), 1'b0);
            end else begin
                wb_read(bank, word, 1'b0);
            end
        end
        bus_release();
    endtask

    initial begin
        rst_n        = 1'b0;
        wb_req       = '0;
        verdict_done = 1'b0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int w = 0; w < BANK_WORDS; w++) begin
                model[2'(b)][IDX_W'(w)] = '0;
            end
        end
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        check_reset_values();
        write_read_back();
        bank_isolation();
        out_of_range_access();
        random_traffic();
        repeat (4) @(posedge clk);
        verdict_done = 1'b1;
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin
        #(WDOG_CYCLES * CLK_PERIOD);
        abort_run("ERROR: watchdog expired before the tests finished");
    end

    // run stopped by an assertion or any other abort
    final begin
        if (!verdict_done) begin
            $display("*** TEST FAILED ***");
        end
    end

endmodule

// File: sim.f
verilog/ahb_pkg.sv
verilog/wb_bank_dispatch.sv
verilog/ahb_bank_bridge.sv
verilog/ahb_sram_bank.sv
verilog/wb_resp_collect.sv
verilog/ahb_mem_subsys.sv
dv/ahb_mem_subsys_sva.sv
dv/tb_ahb_mem_subsys.sv

// File: run.sh
#!/bin/sh
# build and run the banked memory testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_ahb_mem_subsys -f sim.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qF -- '*** TEST FAILED ***' sim.log && exit 1
grep -qF -- '*** TEST PASSED ***' sim.log || exit 1
exit 0
